// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int MAX_CYCLES    = 4;
  localparam int RAM_ADDR_BITS = 10;

  // Bit positions in F
  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  localparam logic [15:0] RESET_SP = 16'hFFFE;

  typedef enum logic [1:0] {
    T1,
    T2,
    T3,
    T4
  } t_phase_t;

  typedef enum logic [1:0] {
    ADDR_PC,
    ADDR_SP,
    ADDR_HL
  } addr_src_t;

  typedef enum logic [1:0] {
    DATA_BUS_OP_READ,
    DATA_BUS_OP_WRITE,
    DATA_BUS_OP_ALU_ONLY
  } data_bus_op_t;

  typedef enum logic [3:0] {
    REG_A,
    REG_B,
    REG_C,
    REG_D,
    REG_E,
    REG_H,
    REG_L,
    REG_F,
    REG_IR,
    REG_NONE
  } reg_sel_t;

  typedef enum logic [1:0] {
    IDU_NONE,
    IDU_INC,
    IDU_DEC
  } idu_op_t;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_OR,
    ALU_INC
  } alu_op_t;

  typedef struct packed {
    addr_src_t    addr_src;
    data_bus_op_t data_bus_op;
    reg_sel_t     data_bus_sel;  // Read destination or write source
    idu_op_t      idu_op;        // Applied to the addr_src register at T4
    alu_op_t      alu_op;
    reg_sel_t     alu_dst;
    reg_sel_t     alu_src;
    logic         halt;
  } cycle_word_t;

  typedef logic [$clog2(MAX_CYCLES)-1:0] cycle_count_t;

  typedef struct packed {
    cycle_count_t                       num_cycles;  // Index of last cycle
    cycle_word_t [MAX_CYCLES-1:0] cycles;
  } control_word_t;

  typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  flags;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [7:0]  e;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [7:0]  ir;
    logic [15:0] pc;
    logic [15:0] sp;
  } cpu_regs_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] addr;
    logic [7:0]  data;
  } mem_write_t;

  typedef struct packed {
    logic                     en;
    logic [RAM_ADDR_BITS-1:0] addr;
    logic [7:0]               data;
  } mem_load_t;

  // Opcode fetch that closes every instruction
  localparam cycle_word_t FETCH_CYCLE = '{
    addr_src:     ADDR_PC,
    data_bus_op:  DATA_BUS_OP_READ,
    data_bus_sel: REG_IR,
    idu_op:       IDU_INC,
    alu_op:       ALU_NONE,
    alu_dst:      REG_NONE,
    alu_src:      REG_NONE,
    halt:         1'b0
  };

  localparam control_word_t NOP_WORD = '{
    num_cycles: '0,
    cycles:     {MAX_CYCLES{FETCH_CYCLE}}
  };

endpackage

`default_nettype wire

// File: control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom import cpu_pkg::*; (
  input  wire logic [7:0]    opcode,
  output control_word_t      control_word
);

  // Single bus cycle with no ALU work
  function automatic cycle_word_t bus_cycle(addr_src_t src, data_bus_op_t op,
                                            reg_sel_t sel, idu_op_t idu);
    cycle_word_t cw;
    cw = FETCH_CYCLE;
    cw.addr_src     = src;
    cw.data_bus_op  = op;
    cw.data_bus_sel = sel;
    cw.idu_op       = idu;
    return cw;
  endfunction

  function automatic control_word_t with_fetch(cycle_word_t first_cycle);
    control_word_t cw;
    cw = NOP_WORD;
    cw.num_cycles = 1;
    cw.cycles[0]  = first_cycle;
    cw.cycles[1]  = FETCH_CYCLE;
    return cw;
  endfunction

  // ALU op overlaps the next fetch
  function automatic control_word_t alu_word(alu_op_t op, reg_sel_t src);
    control_word_t cw;
    cw = NOP_WORD;
    cw.cycles[0].alu_op  = op;
    cw.cycles[0].alu_dst = REG_A;
    cw.cycles[0].alu_src = src;
    return cw;
  endfunction

  always_comb begin
    control_word = NOP_WORD;
    case (opcode)
      8'h06: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_B, IDU_INC));
      8'h0E: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_C, IDU_INC));
      8'h16: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_D, IDU_INC));
      8'h1E: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_E, IDU_INC));
      8'h26: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_H, IDU_INC));
      8'h2E: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_L, IDU_INC));
      8'h3E: control_word = with_fetch(bus_cycle(ADDR_PC, DATA_BUS_OP_READ, REG_A, IDU_INC));
      8'h22: control_word = with_fetch(bus_cycle(ADDR_HL, DATA_BUS_OP_WRITE, REG_A, IDU_INC));
      8'h77: control_word = with_fetch(bus_cycle(ADDR_HL, DATA_BUS_OP_WRITE, REG_A, IDU_NONE));
      8'h3C: control_word = alu_word(ALU_INC, REG_A);
      8'h80: control_word = alu_word(ALU_ADD, REG_B);
      8'h90: control_word = alu_word(ALU_SUB, REG_B);
      8'hA0: control_word = alu_word(ALU_AND, REG_B);
      8'hA8: control_word = alu_word(ALU_XOR, REG_B);
      8'hB0: control_word = alu_word(ALU_OR, REG_B);
      8'h76: begin  // HALT has no fetch
        control_word.cycles[0]      = bus_cycle(ADDR_PC, DATA_BUS_OP_ALU_ONLY, REG_NONE, IDU_NONE);
        control_word.cycles[0].halt = 1'b1;
      end
      8'hF5: begin
        control_word.num_cycles = 3;
        // Pre-decrement SP, then high byte first
        control_word.cycles[0] = bus_cycle(ADDR_SP, DATA_BUS_OP_ALU_ONLY, REG_NONE, IDU_DEC);
        control_word.cycles[1] = bus_cycle(ADDR_SP, DATA_BUS_OP_WRITE, REG_A, IDU_DEC);
        control_word.cycles[2] = bus_cycle(ADDR_SP, DATA_BUS_OP_WRITE, REG_F, IDU_NONE);
        control_word.cycles[3] = FETCH_CYCLE;
      end
      default: control_word = NOP_WORD;  // NOP and anything unsupported
    endcase
  end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  alu_op_t          op,
  input  wire logic [7:0]  a,
  input  wire logic [7:0]  b,
  input  wire logic [7:0]  flags_in,
  output logic      [7:0]  result,
  output logic      [7:0]  flags_out
);

  logic [8:0] sum;
  logic [4:0] half;  // Carry/borrow out of bit 3
  logic       z;
  logic       n;
  logic       h;
  logic       c;

  always_comb begin
    sum    = {1'b0, a};
    half   = {1'b0, a[3:0]};
    result = a;
    n      = flags_in[FLAG_N];
    h      = flags_in[FLAG_H];
    c      = flags_in[FLAG_C];
    case (op)
      ALU_ADD: begin
        sum  = {1'b0, a} + {1'b0, b};
        half = {1'b0, a[3:0]} + {1'b0, b[3:0]};
        n    = 1'b0;
        h    = half[4];
        c    = sum[8];
      end
      ALU_SUB: begin
        sum  = {1'b0, a} - {1'b0, b};
        half = {1'b0, a[3:0]} - {1'b0, b[3:0]};
        n    = 1'b1;
        h    = half[4];
        c    = sum[8];  // Borrow
      end
      ALU_INC: begin
        sum  = {1'b0, a} + 9'd1;
        half = {1'b0, a[3:0]} + 5'd1;
        n    = 1'b0;
        h    = half[4];  // C kept
      end
      default: ;
    endcase
    case (op)
      ALU_ADD, ALU_SUB, ALU_INC: result = sum[7:0];
      ALU_AND: result = a & b;
      ALU_XOR: result = a ^ b;
      ALU_OR:  result = a | b;
      default: result = a;
    endcase
    if (op == ALU_AND || op == ALU_XOR || op == ALU_OR) begin
      n = 1'b0;
      h = (op == ALU_AND);
      c = 1'b0;
    end
    z = (op == ALU_NONE) ? flags_in[FLAG_Z] : (result == 8'h00);
    flags_out         = 8'h00;  // Low nibble always zero
    flags_out[FLAG_Z] = z;
    flags_out[FLAG_N] = n;
    flags_out[FLAG_H] = h;
    flags_out[FLAG_C] = c;
  end

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  output logic      [15:0] addr_bus,
  output logic      [7:0]  wdata,
  input  wire logic [7:0]  rdata,
  output logic             mem_read,
  output logic             mem_write,
  output logic      [7:0]  opcode,
  input  control_word_t    control_word,
  output alu_op_t          alu_op,
  output logic      [7:0]  alu_a,
  output logic      [7:0]  alu_b,
  output logic      [7:0]  alu_flags,
  input  wire logic [7:0]  alu_result,
  input  wire logic [7:0]  alu_flags_out,
  output logic             halted
);

  cpu_regs_t     regs;
  cpu_regs_t     regs_t4;  // Register state after the T4 edge
  control_word_t cur_word;
  cycle_word_t   cur;
  cycle_count_t  cycle_count;
  t_phase_t      phase;

  function automatic logic [7:0] get_reg(cpu_regs_t r, reg_sel_t sel);
    case (sel)
      REG_A:   return r.a;
      REG_B:   return r.b;
      REG_C:   return r.c;
      REG_D:   return r.d;
      REG_E:   return r.e;
      REG_H:   return r.h;
      REG_L:   return r.l;
      REG_F:   return r.flags;
      REG_IR:  return r.ir;
      default: return 8'h00;
    endcase
  endfunction

  function automatic cpu_regs_t put_reg(cpu_regs_t r, reg_sel_t sel, logic [7:0] val);
    cpu_regs_t nr;
    nr = r;
    case (sel)
      REG_A:   nr.a = val;
      REG_B:   nr.b = val;
      REG_C:   nr.c = val;
      REG_D:   nr.d = val;
      REG_E:   nr.e = val;
      REG_H:   nr.h = val;
      REG_L:   nr.l = val;
      REG_F:   nr.flags = {val[7:4], 4'h0};
      REG_IR:  nr.ir = val;
      default: ;
    endcase
    return nr;
  endfunction

  function automatic logic [15:0] addr_of(cpu_regs_t r, addr_src_t src);
    case (src)
      ADDR_SP: return r.sp;
      ADDR_HL: return {r.h, r.l};
      default: return r.pc;
    endcase
  endfunction

  // Incrementer/decrementer writes back into the address source
  function automatic cpu_regs_t apply_idu(cpu_regs_t r, addr_src_t src, idu_op_t op);
    cpu_regs_t   nr;
    logic [15:0] val;
    nr  = r;
    val = addr_of(r, src);
    case (op)
      IDU_INC: val = val + 16'd1;
      IDU_DEC: val = val - 16'd1;
      default: ;
    endcase
    case (src)
      ADDR_SP: nr.sp = val;
      ADDR_HL: {nr.h, nr.l} = val;
      default: nr.pc = val;
    endcase
    return nr;
  endfunction

  assign cur       = cur_word.cycles[cycle_count];
  assign opcode    = regs.ir;
  assign alu_op    = cur.alu_op;
  assign alu_a     = get_reg(regs, cur.alu_dst);
  assign alu_b     = get_reg(regs, cur.alu_src);
  assign alu_flags = regs.flags;

  always_comb begin
    regs_t4 = apply_idu(regs, cur.addr_src, cur.idu_op);
    if (cur.alu_op != ALU_NONE) begin
      regs_t4       = put_reg(regs_t4, cur.alu_dst, alu_result);
      regs_t4.flags = alu_flags_out;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs        <= '{pc: 16'h0000, sp: RESET_SP, default: '0};
      cur_word    <= NOP_WORD;  // First cycle fetches from 0
      cycle_count <= '0;
      phase       <= T1;
      mem_read    <= 1'b0;
      mem_write   <= 1'b0;
      halted      <= 1'b0;
    end else if (!halted) begin
      case (phase)
        T1: phase <= T2;
        T2: begin
          mem_read  <= (cur.data_bus_op == DATA_BUS_OP_READ);
          mem_write <= (cur.data_bus_op == DATA_BUS_OP_WRITE);
          phase     <= T3;
        end
        T3: begin
          if (cur.data_bus_op == DATA_BUS_OP_READ)
            regs <= put_reg(regs, cur.data_bus_sel, rdata);
          mem_read  <= 1'b0;
          mem_write <= 1'b0;
          phase     <= T4;
        end
        T4: begin
          regs  <= regs_t4;
          phase <= T1;
          if (cur.halt)
            halted <= 1'b1;
          if (cycle_count == cur_word.num_cycles) begin
            cycle_count <= '0;
            cur_word    <= control_word;  // IR was just fetched
          end else begin
            cycle_count <= cycle_count + 1'b1;
          end
        end
        default: phase <= T1;
      endcase
    end
  end

  // Bus payload
  always_ff @(posedge clk) begin
    if (!halted && phase == T1)
      addr_bus <= addr_of(regs, cur.addr_src);
    if (!halted && phase == T2 && cur.data_bus_op == DATA_BUS_OP_WRITE)
      wdata <= get_reg(regs, cur.data_bus_sel);
  end

endmodule

`default_nettype wire

// File: mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mmu import cpu_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [15:0] addr_bus,
  input  wire logic [7:0]  wdata,
  output logic      [7:0]  rdata,
  input  wire logic        mem_read,
  input  wire logic        mem_write,
  input  mem_load_t        load,
  output mem_write_t       write_event
);

  logic [7:0]               ram [2**RAM_ADDR_BITS];
  logic [RAM_ADDR_BITS-1:0] ram_idx;  // Address wraps on low bits

  assign ram_idx = addr_bus[RAM_ADDR_BITS-1:0];

  // Undriven bus reads as FF
  assign rdata = mem_read ? ram[ram_idx] : 8'hFF;

  always_ff @(posedge clk) begin
    if (load.en)
      ram[load.addr] <= load.data;
    else if (mem_write)
      ram[ram_idx] <= wdata;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      write_event <= '0;
    end else begin
      write_event.valid <= mem_write;  // One clock after the write
      if (mem_write) begin
        write_event.addr <= addr_bus;
        write_event.data <= wdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: gb_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb_top import cpu_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  mem_load_t  load,
  output mem_write_t write_event,
  output logic       halted
);

  logic [15:0]   addr_bus;
  logic [7:0]    wdata;
  logic [7:0]    rdata;
  logic          mem_read;
  logic          mem_write;
  logic [7:0]    opcode;
  control_word_t control_word;
  alu_op_t       alu_op;
  logic [7:0]    alu_a;
  logic [7:0]    alu_b;
  logic [7:0]    alu_flags;
  logic [7:0]    alu_result;
  logic [7:0]    alu_flags_out;

  cpu_core u_core (
    .clk           (clk),
    .reset         (reset),
    .addr_bus      (addr_bus),
    .wdata         (wdata),
    .rdata         (rdata),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .opcode        (opcode),
    .control_word  (control_word),
    .alu_op        (alu_op),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_flags     (alu_flags),
    .alu_result    (alu_result),
    .alu_flags_out (alu_flags_out),
    .halted        (halted)
  );

  control_rom u_rom (
    .opcode       (opcode),
    .control_word (control_word)
  );

  alu u_alu (
    .op        (alu_op),
    .a         (alu_a),
    .b         (alu_b),
    .flags_in  (alu_flags),
    .result    (alu_result),
    .flags_out (alu_flags_out)
  );

  mmu u_mmu (
    .clk         (clk),
    .reset       (reset),
    .addr_bus    (addr_bus),
    .wdata       (wdata),
    .rdata       (rdata),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .load        (load),
    .write_event (write_event)
  );

endmodule

`default_nettype wire

// File: cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic mem_read,
  input  wire logic mem_write,
  input  wire logic halted,
  input  t_phase_t  phase
);

  logic strobe;

  assign strobe = mem_read || mem_write;

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write are high together");

  strobe_in_t3: assert property (@(posedge clk) disable iff (reset)
    strobe |-> phase == T3)
    else $error("memory strobe outside phase T3");

  strobe_one_clock: assert property (@(posedge clk) disable iff (reset)
    strobe |=> !strobe)
    else $error("memory strobe held for more than one clock");

  // T4 wraps to T1
  phase_steps: assert property (@(posedge clk) disable iff (reset)
    !halted |=> phase == t_phase_t'($past(phase) + 2'd1))
    else $error("phase did not advance by one step");

  halt_freezes: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted && $stable(phase))
    else $error("phase moved or halted dropped after HALT");

endmodule

bind cpu_core cpu_assertions u_assertions (
  .clk       (clk),
  .reset     (reset),
  .mem_read  (mem_read),
  .mem_write (mem_write),
  .halted    (halted),
  .phase     (phase)
);

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();

  localparam string STIM_FILE      = "cpu_stim.txt";
  localparam int    RESET_CYCLES   = 10;
  localparam int    TIMEOUT_CYCLES = 2000;
  localparam int    QUIET_CYCLES   = 100;

  logic       clk;
  logic       reset;
  mem_load_t  load;
  mem_write_t write_event;
  logic       halted;

  mem_load_t  program_bytes[$];
  mem_write_t exp_writes[$];  // In bus order

  gb_top dut (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .write_event (write_event),
    .halted      (halted)
  );

  always #10 clk = ~clk;

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_write(string name, mem_write_t exp, mem_write_t act);
    if (act !== exp)
      report_failure($sformatf(
        "[ERROR] %s: expected valid=%b addr=%h data=%h, actual valid=%b addr=%h data=%h",
        name, exp.valid, exp.addr, exp.data, act.valid, act.addr, act.data));
  endtask

  task automatic check_halted(string name, logic exp, logic act);
    if (act !== exp)
      report_failure($sformatf("[ERROR] %s: expected halted=%b, actual halted=%b",
                               name, exp, act));
  endtask

  task automatic read_stim();
    int          fd;
    int          n;
    string       line;
    logic [15:0] addr;
    logic [7:0]  data;
    mem_load_t   ld;
    mem_write_t  wr;
    bit          found_end;
    found_end = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
      report_failure($sformatf("cannot open stimulus file %s", STIM_FILE));
    while (!found_end && !$feof(fd)) begin
      if ($fgets(line, fd) == 0 || line[0] == "#" || line[0] == "\n")
        continue;
      if (line[0] == "E") begin
        found_end = 1'b1;
        continue;
      end
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
      if (n != 2 || (line[0] != "P" && line[0] != "W"))
        report_failure($sformatf("bad stimulus line: %s", line));
      if (line[0] == "P") begin
        ld.en   = 1'b1;
        ld.addr = addr[RAM_ADDR_BITS-1:0];
        ld.data = data;
        program_bytes.push_back(ld);
      end else begin
        wr.valid = 1'b1;
        wr.addr  = addr;
        wr.data  = data;
        exp_writes.push_back(wr);
      end
    end
    $fclose(fd);
    if (!found_end)
      report_failure("stimulus file ends without an E line");
  endtask

  task automatic load_program();
    foreach (program_bytes[i]) begin
      @(negedge clk);
      load = program_bytes[i];
    end
    @(negedge clk);
    load = '0;
  endtask

  task automatic wait_write_event(int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (halted && !write_event.valid)
        report_failure($sformatf("CPU halted before write event %0d", idx));
    end while (!write_event.valid && cycles < TIMEOUT_CYCLES);
    if (!write_event.valid)
      report_failure($sformatf("no write event %0d within %0d cycles", idx, TIMEOUT_CYCLES));
  endtask

  // Every event must match the head of the list
  task automatic run_writes();
    int idx;
    idx = 0;
    while (exp_writes.size() > 0) begin
      wait_write_event(idx);
      check_write($sformatf("write %0d", idx), exp_writes[0], write_event);
      void'(exp_writes.pop_front());
      idx++;
    end
  endtask

  task automatic wait_halted();
    int cycles;
    cycles = 0;
    while (!halted && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (write_event.valid)
        report_failure($sformatf("unexpected write event at address %h", write_event.addr));
    end
    check_halted("halt after program", 1'b1, halted);
  endtask

  task automatic check_quiet();
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      if (write_event.valid)
        report_failure($sformatf("write event at address %h while halted", write_event.addr));
      check_halted("halted stays high", 1'b1, halted);
    end
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    load  = '0;
    read_stim();
    load_program();  // Reset stays high through the preload
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    run_writes();
    wait_halted();
    check_quiet();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_stim.txt
# P addr byte: program byte loaded into RAM during reset
# W addr byte: expected write event in bus order; E ends the file
P 0000 3E  # LD A,5A
P 0001 5A
P 0002 26  # LD H,01
P 0003 01
P 0004 2E  # LD L,00
P 0005 00
P 0006 77  # LD (HL),A
P 0007 0E  # LD C,11
P 0008 11
P 0009 16  # LD D,22
P 000A 22
P 000B 1E  # LD E,33
P 000C 33
P 000D 2E  # LD L,FE
P 000E FE
P 000F 3E  # LD A,C3
P 0010 C3
P 0011 22  # LD (HL+),A three times, L carries into H
P 0012 22
P 0013 22
P 0014 3E  # LD A,3A
P 0015 3A
P 0016 06  # LD B,C6
P 0017 C6
P 0018 80  # ADD A,B
P 0019 F5
P 001A 90  # SUB B
P 001B F5
P 001C 3C  # INC A
P 001D F5
P 001E A0  # AND B
P 001F F5
P 0020 B0  # OR B
P 0021 F5
P 0022 A8  # XOR B
P 0023 F5
P 0024 3E  # LD A,FF
P 0025 FF
P 0026 3C  # INC A
P 0027 F5
P 0028 76  # HALT
W 0100 5A
W 01FE C3
W 01FF C3
W 0200 C3
W FFFD 00  # ADD 3A+C6, Z H C
W FFFC B0
W FFFB 3A  # SUB 00-C6, N H C
W FFFA 70
W FFF9 3B  # INC keeps C
W FFF8 10
W FFF7 02  # AND sets H
W FFF6 20
W FFF5 C6
W FFF4 00
W FFF3 00  # XOR to zero
W FFF2 80
W FFF1 00  # INC FF, Z H
W FFF0 A0
E

// File: list.f
cpu_pkg.sv
control_rom.sv
alu.sv
cpu_core.sv
mmu.sv
gb_top.sv
cpu_assertions.sv
tb_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --assert -j 0
SIM_BIN    := $(BUILD_DIR)/V$(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
